// File: files.f
logic/frv_counters_pkg.sv
logic/frv_counters.sv
logic/frv_counter_csrs.sv
logic/frv_counter_subsys.sv
test/frv_counter_subsys_tb.sv

// File: Makefile
SRCS := $(shell cat files.f)

.PHONY: all run clean

all: run

obj_dir/Vfrv_counter_subsys_tb: $(SRCS) files.f
	verilator --binary --timing --top-module frv_counter_subsys_tb -f files.f

sim.log: obj_dir/Vfrv_counter_subsys_tb
	./obj_dir/Vfrv_counter_subsys_tb > sim.log 2>&1 || true

run: obj_dir/Vfrv_counter_subsys_tb
	./obj_dir/Vfrv_counter_subsys_tb > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then \
		echo "Simulation failed"; exit 1; \
	fi
	@grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: test/frv_counter_subsys_tb.sv
// ####################
// Random test of the counter subsystem against a cycle model
// Model updates on rising edges and checks run on falling edges
// ####################

`timescale 1ns/100ps
`default_nettype none

module frv_counter_subsys_tb
    import frv_counters_pkg::*;
;
    localparam int unsigned CYCLES_T1 = 40;
    localparam int unsigned CYCLES_T2 = 60 * 4 + 20 * 2;
    localparam int unsigned CYCLES_T3 = 20 + 600 + 10;
    localparam int unsigned CYCLES_T4 = 8 * (4 + 30 * 2 + 12);
    localparam int unsigned CYCLES_T5 = 20 * 4 + 20;
    localparam int unsigned WATCHDOG_CYCLES =
        CYCLES_T1 + CYCLES_T2 + CYCLES_T3 + CYCLES_T4 + CYCLES_T5 + 500;

    logic        g_clk = 1'b0;
    logic        g_resetn = 1'b0;
    logic        instr_ret = 1'b0;
    logic        timer_interrupt;
    logic        mmio_en = 1'b0;
    logic        mmio_wen = 1'b0;
    logic [31:0] mmio_addr = '0;
    logic [31:0] mmio_wdata = '0;
    logic [31:0] mmio_rdata;
    logic        mmio_error;
    logic        csr_en = 1'b0;
    logic        csr_wen = 1'b0;
    logic [11:0] csr_addr = '0;
    logic [31:0] csr_wdata = '0;
    logic [31:0] csr_rdata;
    logic        csr_error;
    logic        ret_active = 1'b0;        // Random instr_ret pulses on
    int unsigned errors = 0;
    int unsigned checks = 0;
    int unsigned tests = 0;

    // Model state
    ctr_t m_cycle, m_time, m_instret, m_cmp, edge_count;
    logic [2:0] m_inh;
    logic m_irq, exp_mmio_err, exp_csr_err, irq_next;
    logic [31:0] exp_mmio_rdata, exp_csr_rdata, off;

    always #50 g_clk = ~g_clk;

    frv_counter_subsys frv_counter_subsys_inst (
        .g_clk(g_clk), .g_resetn(g_resetn), .instr_ret(instr_ret),
        .timer_interrupt(timer_interrupt),
        .mmio_en(mmio_en), .mmio_wen(mmio_wen), .mmio_addr(mmio_addr),
        .mmio_wdata(mmio_wdata), .mmio_rdata(mmio_rdata), .mmio_error(mmio_error),
        .csr_en(csr_en), .csr_wen(csr_wen), .csr_addr(csr_addr),
        .csr_wdata(csr_wdata), .csr_rdata(csr_rdata), .csr_error(csr_error)
    );

    always @(posedge g_clk) begin
        if (!g_resetn) begin
            m_cycle = '0;
            m_time = '0;
            m_instret = '0;
            m_cmp = '1;
            edge_count = '0;
            m_inh = '0;
            m_irq = 1'b0;
            exp_mmio_rdata = '0;
            exp_mmio_err = 1'b0;
            exp_csr_rdata = '0;
            exp_csr_err = 1'b0;
        end else begin
            edge_count = edge_count + 1;
            irq_next = (m_time >= m_cmp);   // Taken from the old values like a register
            off = {20'd0, mmio_addr[11:0]};
            if (mmio_en) begin
                exp_mmio_err = !(off == 0 || off == 4 || off == 8 || off == 12);
                case (off)
                    0: exp_mmio_rdata = m_time[31:0];
                    4: exp_mmio_rdata = m_time[63:32];
                    8: exp_mmio_rdata = m_cmp[31:0];
                    12: exp_mmio_rdata = m_cmp[63:32];
                    default: exp_mmio_rdata = '0;
                endcase
            end
            if (csr_en) begin
                exp_csr_err = 1'b0;
                case (csr_addr)
                    12'hC00: exp_csr_rdata = m_cycle[31:0];
                    12'hC01: exp_csr_rdata = m_time[31:0];
                    12'hC02: exp_csr_rdata = m_instret[31:0];
                    12'hC80: exp_csr_rdata = m_cycle[63:32];
                    12'hC81: exp_csr_rdata = m_time[63:32];
                    12'hC82: exp_csr_rdata = m_instret[63:32];
                    12'h320: exp_csr_rdata = {29'd0, m_inh};
                    default: exp_csr_err = 1'b1;
                endcase
                if (csr_wen && csr_addr != 12'h320) exp_csr_err = 1'b1;
                if (exp_csr_err) exp_csr_rdata = '0;
            end
            if (!m_inh[0]) m_cycle = m_cycle + 1;
            if (instr_ret && !m_inh[2]) m_instret = m_instret + 1;
            if (mmio_en && mmio_wen && off == 4) m_time[63:32] = mmio_wdata;
            else if (mmio_en && mmio_wen && off == 0) m_time[31:0] = mmio_wdata;
            else if (!m_inh[1]) m_time = m_time + 1;
            if (mmio_en && mmio_wen && off == 12) m_cmp[63:32] = mmio_wdata;
            if (mmio_en && mmio_wen && off == 8) m_cmp[31:0] = mmio_wdata;
            if (csr_en && csr_wen && csr_addr == 12'h320) m_inh = csr_wdata[2:0];
            m_irq = irq_next;
        end
    end

    always @(negedge g_clk) instr_ret = ret_active ? 1'($urandom % 2) : 1'b0;

    task automatic check_ctr(input string what, input ctr_t got, input ctr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0d ns %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_word(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0d ns %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0d ns %s: got %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic mmio_access(input logic wen, input logic [31:0] addr,
                               input logic [31:0] data);
        @(negedge g_clk);
        mmio_en = 1'b1;
        mmio_wen = wen;
        mmio_addr = addr;
        mmio_wdata = data;
        @(negedge g_clk);
        mmio_en = 1'b0;
        mmio_wen = 1'b0;
        check_word("mmio rdata", mmio_rdata, exp_mmio_rdata);
        check_flag("mmio error", mmio_error, exp_mmio_err);
    endtask

    task automatic csr_access(input logic wen, input logic [11:0] addr,
                              input logic [31:0] data);
        @(negedge g_clk);
        csr_en = 1'b1;
        csr_wen = wen;
        csr_addr = addr;
        csr_wdata = data;
        @(negedge g_clk);
        csr_en = 1'b0;
        csr_wen = 1'b0;
        check_word("csr rdata", csr_rdata, exp_csr_rdata);
        check_flag("csr error", csr_error, exp_csr_err);
    endtask

    // Two half reads with the model value taken at each edge
    task automatic read_ctr(input string what, input logic [11:0] lo_addr);
        ctr_t got;
        ctr_t exp;
        csr_access(1'b0, lo_addr, '0);
        got[31:0] = csr_rdata;
        exp[31:0] = exp_csr_rdata;
        csr_access(1'b0, lo_addr | 12'h080, '0);
        got[63:32] = csr_rdata;
        exp[63:32] = exp_csr_rdata;
        check_ctr(what, got, exp);
    endtask

    // One of the six counter halves
    function automatic logic [11:0] random_counter_csr();
        logic [11:0] addr;
        addr = 12'hC00 + 12'($urandom % 3);
        if ($urandom % 2 == 1) addr = addr | 12'h080;   // High half
        return addr;
    endfunction

    function automatic logic [11:0] random_unmapped_csr();
        logic [11:0] addr;
        addr = 12'($urandom);
        while (addr == 12'h320 || (addr & 12'hF7C) == 12'hC00) begin
            addr = 12'($urandom);
        end
        return addr;
    endfunction

    task automatic end_test(input string name, input int unsigned err_before);
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - err_before);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * 100);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        int unsigned e0;
        logic [31:0] a;
        logic seen;
        void'($urandom(77));
        repeat (3) @(negedge g_clk);
        g_resetn = 1'b1;

        e0 = errors;
        read_ctr("cycle", CSR_CYCLE);
        read_ctr("time", CSR_TIME);
        read_ctr("instret", CSR_INSTRET);
        // A read returns the count from before its edge
        csr_access(1'b0, CSR_CYCLE, '0);
        check_word("cycle vs edges", csr_rdata, edge_count[31:0] - 32'd1);
        csr_access(1'b0, CSR_TIME, '0);
        check_word("time vs edges", csr_rdata, edge_count[31:0] - 32'd1);
        csr_access(1'b0, CSR_INSTRET, '0);
        check_word("instret zero", csr_rdata, '0);
        mmio_access(1'b0, MMIO_BASE_ADDR + 8, '0);
        check_word("mtimecmp lo", mmio_rdata, 32'hFFFF_FFFF);
        mmio_access(1'b0, MMIO_BASE_ADDR + 12, '0);
        check_word("mtimecmp hi", mmio_rdata, 32'hFFFF_FFFF);
        check_flag("irq after reset", timer_interrupt, 1'b0);
        end_test("reset values", e0);

        e0 = errors;
        repeat (60) begin
            a = MMIO_BASE_ADDR + 4 * ($urandom % 4);
            mmio_access(1'b1, a, $urandom);
            mmio_access(1'b0, a, '0);
        end
        repeat (20) begin
            a = ($urandom & 32'hFFFF_F000) | (16 + $urandom % 4080);
            mmio_access(1'($urandom % 2), a, $urandom);
            check_flag("unmapped mmio", mmio_error, 1'b1);
        end
        end_test("mmio registers", e0);

        e0 = errors;
        mmio_access(1'b1, MMIO_BASE_ADDR + 12, 32'hFFFF_FFFF);
        mmio_access(1'b1, MMIO_BASE_ADDR + 4, '0);
        mmio_access(1'b1, MMIO_BASE_ADDR + 0, '0);
        mmio_access(1'b1, MMIO_BASE_ADDR + 8, m_time[31:0] + 200 + $urandom % 200);
        mmio_access(1'b1, MMIO_BASE_ADDR + 12, '0);
        seen = 1'b0;
        for (int i = 0; i < 600 && !seen; i++) begin
            @(negedge g_clk);
            check_flag("timer irq", timer_interrupt, m_irq);
            seen = timer_interrupt;
        end
        check_flag("timer irq reached", seen, 1'b1);
        mmio_access(1'b1, MMIO_BASE_ADDR + 12, 32'hFFFF_FFFF);
        @(negedge g_clk);
        check_flag("irq cleared", timer_interrupt, 1'b0);
        end_test("timer interrupt", e0);

        e0 = errors;
        ret_active = 1'b1;
        repeat (8) begin
            csr_access(1'b1, CSR_MCOUNTINHIBIT, $urandom);
            csr_access(1'b0, CSR_MCOUNTINHIBIT, '0);
            repeat (30) csr_access(1'b0, random_counter_csr(), '0);
            read_ctr("cycle", CSR_CYCLE);
            read_ctr("time", CSR_TIME);
            read_ctr("instret", CSR_INSTRET);
        end
        end_test("instret and inhibit", e0);

        e0 = errors;
        csr_access(1'b1, CSR_MCOUNTINHIBIT, '0);
        repeat (20) begin
            csr_access(1'b1, random_counter_csr(), $urandom);
            check_flag("counter write", csr_error, 1'b1);
            csr_access(1'($urandom % 2), random_unmapped_csr(), $urandom);
            check_flag("unmapped csr", csr_error, 1'b1);
        end
        ret_active = 1'b0;
        read_ctr("cycle", CSR_CYCLE);
        read_ctr("time", CSR_TIME);
        read_ctr("instret", CSR_INSTRET);
        end_test("csr errors", e0);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/frv_counter_subsys.sv
// ####################
// Counter subsystem top, CSR access block next to the counter block
// Both buses have a one cycle registered response and no back-pressure
// ####################

`timescale 1ns/100ps
`default_nettype none

module frv_counter_subsys
    import frv_counters_pkg::*;
(
    input  logic        g_clk,
    input  logic        g_resetn,

    input  logic        instr_ret,
    output logic        timer_interrupt,

    input  logic        mmio_en,
    input  logic        mmio_wen,
    input  logic [31:0] mmio_addr,
    input  logic [31:0] mmio_wdata,
    output logic [31:0] mmio_rdata,
    output logic        mmio_error,

    input  logic        csr_en,
    input  logic        csr_wen,
    input  logic [11:0] csr_addr,
    input  logic [31:0] csr_wdata,
    output logic [31:0] csr_rdata,
    output logic        csr_error
);

    ctr_t ctr_cycle;
    ctr_t ctr_time;
    ctr_t ctr_instret;
    logic inhibit_cy;
    logic inhibit_tm;
    logic inhibit_ir;

    frv_counters frv_counters_inst (
        .g_clk           (g_clk),
        .g_resetn        (g_resetn),
        .instr_ret       (instr_ret),
        .timer_interrupt (timer_interrupt),
        .ctr_time        (ctr_time),
        .ctr_cycle       (ctr_cycle),
        .ctr_instret     (ctr_instret),
        .inhibit_cy      (inhibit_cy),
        .inhibit_tm      (inhibit_tm),
        .inhibit_ir      (inhibit_ir),
        .mmio_en         (mmio_en),
        .mmio_wen        (mmio_wen),
        .mmio_addr       (mmio_addr),
        .mmio_wdata      (mmio_wdata),
        .mmio_rdata      (mmio_rdata),
        .mmio_error      (mmio_error)
    );

    // Counter values in, inhibit lines out
    frv_counter_csrs frv_counter_csrs_inst (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .csr_en      (csr_en),
        .csr_wen     (csr_wen),
        .csr_addr    (csr_addr),
        .csr_wdata   (csr_wdata),
        .csr_rdata   (csr_rdata),
        .csr_error   (csr_error),
        .ctr_cycle   (ctr_cycle),
        .ctr_time    (ctr_time),
        .ctr_instret (ctr_instret),
        .inhibit_cy  (inhibit_cy),
        .inhibit_tm  (inhibit_tm),
        .inhibit_ir  (inhibit_ir)
    );

endmodule

`default_nettype wire

// File: logic/frv_counter_csrs.sv
// ####################
// CSR access to the counter halves and mcountinhibit
// Counter CSRs are read only, a write to one returns csr_error
// Response is valid one cycle after csr_en
// ####################

`timescale 1ns/100ps
`default_nettype none

module frv_counter_csrs
    import frv_counters_pkg::*;
(
    input  logic        g_clk,
    input  logic        g_resetn,

    input  logic        csr_en,
    input  logic        csr_wen,
    input  logic [11:0] csr_addr,
    input  logic [31:0] csr_wdata,
    output logic [31:0] csr_rdata,
    output logic        csr_error,

    input  ctr_t        ctr_cycle,
    input  ctr_t        ctr_time,
    input  ctr_t        ctr_instret,

    output logic        inhibit_cy,
    output logic        inhibit_tm,
    output logic        inhibit_ir
);

    logic [2:0]  mcountinhibit;
    logic [31:0] rd_word;
    logic        is_ctr;        // One of the six counter halves
    logic        is_inh;
    logic        n_csr_error;
    logic [31:0] n_csr_rdata;
    logic        inh_wr;

    always_comb begin
        rd_word = '0;
        is_ctr  = 1'b0;
        is_inh  = 1'b0;
        case (csr_addr)
            CSR_CYCLE: begin
                rd_word = ctr_cycle[31:0];
                is_ctr  = 1'b1;
            end
            CSR_TIME: begin
                rd_word = ctr_time[31:0];
                is_ctr  = 1'b1;
            end
            CSR_INSTRET: begin
                rd_word = ctr_instret[31:0];
                is_ctr  = 1'b1;
            end
            CSR_CYCLEH: begin
                rd_word = ctr_cycle[63:32];
                is_ctr  = 1'b1;
            end
            CSR_TIMEH: begin
                rd_word = ctr_time[63:32];
                is_ctr  = 1'b1;
            end
            CSR_INSTRETH: begin
                rd_word = ctr_instret[63:32];
                is_ctr  = 1'b1;
            end
            CSR_MCOUNTINHIBIT: begin
                rd_word = {29'd0, mcountinhibit};  // Upper bits read zero
                is_inh  = 1'b1;
            end
            default: ;
        endcase
    end

    assign n_csr_error = !(is_ctr || is_inh) || (csr_wen && is_ctr);
    assign n_csr_rdata = n_csr_error ? 32'd0 : rd_word;
    assign inh_wr      = csr_en && csr_wen && is_inh;

    // New inhibit value applies from the next edge
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mcountinhibit <= '0;
        end else if (inh_wr) begin
            mcountinhibit <= csr_wdata[2:0];
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            csr_rdata <= '0;
            csr_error <= 1'b0;
        end else if (csr_en) begin
            csr_rdata <= n_csr_rdata;
            csr_error <= n_csr_error;
        end
    end

    assign inhibit_cy = mcountinhibit[INH_CY];
    assign inhibit_tm = mcountinhibit[INH_TM];
    assign inhibit_ir = mcountinhibit[INH_IR];

endmodule

`default_nettype wire

// File: logic/frv_counters.sv
// ####################
// Cycle, instret and mtime counters plus mtimecmp and the timer interrupt
// MMIO response is valid one cycle after mmio_en and held until the next access
// Unmapped offsets give mmio_error with zero read data
// ####################

`timescale 1ns/100ps
`default_nettype none

module frv_counters
    import frv_counters_pkg::*;
(
    input  logic        g_clk,
    input  logic        g_resetn,

    input  logic        instr_ret,       // One instruction retired this cycle
    output logic        timer_interrupt,

    output ctr_t        ctr_time,
    output ctr_t        ctr_cycle,
    output ctr_t        ctr_instret,

    input  logic        inhibit_cy,
    input  logic        inhibit_tm,
    input  logic        inhibit_ir,

    input  logic        mmio_en,
    input  logic        mmio_wen,
    input  logic [31:0] mmio_addr,
    input  logic [31:0] mmio_wdata,
    output logic [31:0] mmio_rdata,
    output logic        mmio_error
);

    logic [31:0] mmio_off;
    logic        sel_mtime_lo;
    logic        sel_mtime_hi;
    logic        sel_mtimecmp_lo;
    logic        sel_mtimecmp_hi;
    logic        wr_mtime_lo;
    logic        wr_mtime_hi;
    logic        wr_mtimecmp_lo;
    logic        wr_mtimecmp_hi;
    logic [31:0] n_mmio_rdata;
    logic        n_mmio_error;

    ctr_t        mtime;
    ctr_t        mtimecmp;

    // Offset within the window, base bits ignored
    assign mmio_off = mmio_addr & ~MMIO_BASE_MASK;

    assign sel_mtime_lo    = mmio_en &&
        (mmio_off == ((MMIO_BASE_ADDR + MMIO_MTIME_OFF) & ~MMIO_BASE_MASK));
    assign sel_mtime_hi    = mmio_en &&
        (mmio_off == ((MMIO_BASE_ADDR + MMIO_MTIME_HI_OFF) & ~MMIO_BASE_MASK));
    assign sel_mtimecmp_lo = mmio_en &&
        (mmio_off == ((MMIO_BASE_ADDR + MMIO_MTIMECMP_OFF) & ~MMIO_BASE_MASK));
    assign sel_mtimecmp_hi = mmio_en &&
        (mmio_off == ((MMIO_BASE_ADDR + MMIO_MTIMECMP_HI_OFF) & ~MMIO_BASE_MASK));

    assign wr_mtime_lo    = sel_mtime_lo && mmio_wen;
    assign wr_mtime_hi    = sel_mtime_hi && mmio_wen;
    assign wr_mtimecmp_lo = sel_mtimecmp_lo && mmio_wen;
    assign wr_mtimecmp_hi = sel_mtimecmp_hi && mmio_wen;

    // A half write replaces the tick on that edge
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mtime <= '0;
        end else if (wr_mtime_hi) begin
            mtime <= {mmio_wdata, mtime[31:0]};
        end else if (wr_mtime_lo) begin
            mtime <= {mtime[63:32], mmio_wdata};
        end else if (!inhibit_tm) begin
            mtime <= mtime + 64'd1;
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mtimecmp <= MTIMECMP_RESET;
        end else if (wr_mtimecmp_hi) begin
            mtimecmp <= {mmio_wdata, mtimecmp[31:0]};
        end else if (wr_mtimecmp_lo) begin
            mtimecmp <= {mtimecmp[63:32], mmio_wdata};
        end
    end

    // Level interrupt, one cycle behind the compare
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            timer_interrupt <= 1'b0;
        end else begin
            timer_interrupt <= (mtime >= mtimecmp);
        end
    end

    // Selects are one-hot, so an OR of masked words is enough
    assign n_mmio_rdata = ({32{sel_mtime_lo}}    & mtime[31:0])     |
                          ({32{sel_mtime_hi}}    & mtime[63:32])    |
                          ({32{sel_mtimecmp_lo}} & mtimecmp[31:0])  |
                          ({32{sel_mtimecmp_hi}} & mtimecmp[63:32]);

    assign n_mmio_error = !(sel_mtime_lo || sel_mtime_hi ||
                            sel_mtimecmp_lo || sel_mtimecmp_hi);

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mmio_rdata <= '0;
            mmio_error <= 1'b0;
        end else if (mmio_en) begin  // Held between accesses
            mmio_rdata <= n_mmio_rdata;
            mmio_error <= n_mmio_error;
        end
    end

    assign ctr_time = mtime;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            ctr_instret <= '0;
        end else if (instr_ret && !inhibit_ir) begin
            ctr_instret <= ctr_instret + 64'd1;
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            ctr_cycle <= '0;
        end else if (!inhibit_cy) begin
            ctr_cycle <= ctr_cycle + 64'd1;
        end
    end

endmodule

`default_nettype wire

// File: logic/frv_counters_pkg.sv
// ####################
// Address maps and reset values for the counter and timer block
// Only the MMIO address bits outside MMIO_BASE_MASK are decoded
// ####################

`default_nettype none

package frv_counters_pkg;

    // Full width counter value
    typedef logic [63:0] ctr_t;

    // MMIO window, 4 KiB
    localparam logic [31:0] MMIO_BASE_ADDR = 32'h0000_1000;
    localparam logic [31:0] MMIO_BASE_MASK = 32'hFFFF_F000;

    // Word offsets within the window
    localparam logic [31:0] MMIO_MTIME_OFF       = 32'd0;
    localparam logic [31:0] MMIO_MTIME_HI_OFF    = 32'd4;
    localparam logic [31:0] MMIO_MTIMECMP_OFF    = 32'd8;
    localparam logic [31:0] MMIO_MTIMECMP_HI_OFF = 32'd12;

    // No interrupt until software programs a compare value
    localparam ctr_t MTIMECMP_RESET = '1;

    // Read only user counters
    localparam logic [11:0] CSR_CYCLE    = 12'hC00;
    localparam logic [11:0] CSR_TIME     = 12'hC01;
    localparam logic [11:0] CSR_INSTRET  = 12'hC02;
    localparam logic [11:0] CSR_CYCLEH   = 12'hC80;
    localparam logic [11:0] CSR_TIMEH    = 12'hC81;
    localparam logic [11:0] CSR_INSTRETH = 12'hC82;

    // Machine counter inhibit
    localparam logic [11:0] CSR_MCOUNTINHIBIT = 12'h320;

    // mcountinhibit bit positions
    localparam int unsigned INH_CY = 0;
    localparam int unsigned INH_TM = 1;
    localparam int unsigned INH_IR = 2;

endpackage

`default_nettype wire
